/* files.f */
rtl/accel_pkg.sv
rtl/accel_regs.sv
rtl/pkt_rd_dma.sv
rtl/beat_fifo.sv
rtl/pattern_matcher.sv
rtl/accel_top.sv
verification/accel_tb.sv

/* rtl/accel_pkg.sv */
package accel_pkg;

  // host and memory word width
  localparam int data_w     = 32;
  localparam int io_addr_w  = 8;
  localparam int mem_addr_w = 10;
  localparam int len_w      = 14;

  // beat buffer between dma and matcher
  localparam int fifo_depth = 8;
  localparam int fifo_ptr_w = $clog2(fifo_depth);
  localparam int fifo_cnt_w = $clog2(fifo_depth + 1);

  // register map, byte offsets
  localparam logic [io_addr_w-1:0] reg_ctrl    = 8'h00;
  localparam logic [io_addr_w-1:0] reg_len     = 8'h04;
  localparam logic [io_addr_w-1:0] reg_addr    = 8'h08;
  localparam logic [io_addr_w-1:0] reg_pattern = 8'h0C;
  localparam logic [io_addr_w-1:0] reg_result  = 8'h14;
  localparam logic [io_addr_w-1:0] reg_error   = 8'h18;

  // reg_ctrl bit positions
  localparam int ctrl_start_bit = 0;
  localparam int ctrl_busy_bit  = 1;
  localparam int ctrl_stop_bit  = 4;
  localparam int ctrl_done_bit  = 8;
  localparam int ctrl_match_bit = 9;

  // reg_error bit positions
  localparam int err_busy_bit = 0;
  localparam int err_zero_bit = 1;

  // job descriptor handed to the read dma
  typedef struct packed {
    logic [mem_addr_w-1:0] addr;
    logic [len_w-1:0]      len;
  } dma_desc_t;

  // one stream beat, byte 0 comes first in the stream
  typedef struct packed {
    logic [data_w-1:0] data;
    logic [2:0]        nbytes;
    logic              last;
  } beat_t;

  // search outcome
  typedef struct packed {
    logic             found;
    logic [len_w-1:0] offset;
  } match_t;

endpackage

/* rtl/accel_regs.sv */
`timescale 1ns/1ps

module accel_regs import accel_pkg::*; (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 io_en,
  input  logic                 io_wen,
  input  logic [io_addr_w-1:0] io_addr,
  input  logic [data_w-1:0]    io_wr_data,
  output logic [data_w-1:0]    io_rd_data,
  output logic                 io_rd_valid,
  output logic                 error,
  input  logic                 error_ack,
  output dma_desc_t            desc,
  output logic                 desc_valid,
  input  logic                 desc_ready,
  output logic                 stop,
  output logic                 init,
  output logic [data_w-1:0]    pattern,
  input  match_t               result,
  input  logic                 result_valid,
  input  logic                 dma_busy
);

  logic [len_w-1:0]      len_q;
  logic [mem_addr_w-1:0] addr_q;
  logic [data_w-1:0]     pattern_q;
  match_t                result_q;
  logic                  result_held_q;
  logic                  job_active_q;
  logic                  done_q;
  logic                  match_q;
  logic [1:0]            err_q;
  logic                  desc_valid_q;
  logic                  stop_q;
  logic                  init_q;
  logic [data_w-1:0]     rd_data_q;
  logic                  rd_valid_q;
  logic                  rd_stall_q;

  logic                  wr;
  logic                  rd;
  logic                  busy;
  logic                  start_req;
  logic                  stop_req;
  logic                  res_accept;
  logic [data_w-1:0]     ctrl_word;

  function automatic logic [data_w-1:0] result_word(match_t r);
    logic [data_w-1:0] w;
    w = '0;
    w[data_w-1] = r.found;
    w[len_w-1:0] = r.offset;
    return w;
  endfunction

  assign wr = io_en && io_wen;
  assign rd = io_en && !io_wen;
  assign start_req = wr && (io_addr == reg_ctrl) && io_wr_data[ctrl_start_bit];
  assign stop_req  = wr && (io_addr == reg_ctrl) && io_wr_data[ctrl_stop_bit];

  // a job counts as busy until its result is back or it is stopped
  assign busy = desc_valid_q || dma_busy || job_active_q;

  // late results of a stopped job are dropped
  assign res_accept = result_valid && job_active_q;

  always_comb begin
    ctrl_word = '0;
    ctrl_word[ctrl_busy_bit]  = busy;
    ctrl_word[ctrl_done_bit]  = done_q;
    ctrl_word[ctrl_match_bit] = match_q;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      result_held_q <= 1'b0;
      job_active_q  <= 1'b0;
      done_q        <= 1'b0;
      match_q       <= 1'b0;
      err_q         <= '0;
      desc_valid_q  <= 1'b0;
      stop_q        <= 1'b0;
      init_q        <= 1'b0;
      rd_valid_q    <= 1'b0;
      rd_stall_q    <= 1'b0;
    end else begin
      stop_q     <= 1'b0;
      init_q     <= 1'b0;
      rd_valid_q <= 1'b0;

      if (desc_valid_q && desc_ready) begin
        desc_valid_q <= 1'b0;
      end

      if (res_accept) begin
        result_held_q <= 1'b1;
        job_active_q  <= 1'b0;
        done_q        <= 1'b1;
        match_q       <= result.found;
      end

      if (error_ack) begin
        err_q <= '0;
      end

      // stop wins over a start in the same write
      if (stop_req) begin
        stop_q <= 1'b1;
        if (busy) begin
          desc_valid_q  <= 1'b0;
          job_active_q  <= 1'b0;
          result_held_q <= 1'b1;
          done_q        <= 1'b1;
          match_q       <= 1'b0;
        end
      end else if (start_req) begin
        if (busy) begin
          err_q[err_busy_bit] <= 1'b1;
        end else if (len_q == '0) begin
          err_q[err_zero_bit] <= 1'b1;
        end else begin
          desc_valid_q  <= 1'b1;
          init_q        <= 1'b1;
          job_active_q  <= 1'b1;
          result_held_q <= 1'b0;
          done_q        <= 1'b0;
          match_q       <= 1'b0;
        end
      end

      // result read waits here while the host holds the address
      if (rd_stall_q) begin
        if (res_accept || result_held_q) begin
          rd_valid_q <= 1'b1;
          rd_stall_q <= 1'b0;
        end
      end else if (rd) begin
        if (io_addr == reg_result && !result_held_q) begin
          rd_stall_q <= 1'b1;
        end else begin
          rd_valid_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr) begin
      case (io_addr)
        reg_len:     len_q     <= io_wr_data[len_w-1:0];
        reg_addr:    addr_q    <= io_wr_data[mem_addr_w-1:0];
        reg_pattern: pattern_q <= io_wr_data;
        default:     ;
      endcase
    end

    if (res_accept) begin
      result_q <= result;
    end
    if (stop_req && busy) begin
      result_q <= '0;
    end

    if (rd_stall_q) begin
      rd_data_q <= res_accept ? result_word(result) : result_word(result_q);
    end else if (rd) begin
      case (io_addr)
        reg_ctrl:    rd_data_q <= ctrl_word;
        reg_len:     rd_data_q <= data_w'(len_q);
        reg_addr:    rd_data_q <= data_w'(addr_q);
        reg_pattern: rd_data_q <= pattern_q;
        reg_result:  rd_data_q <= result_word(result_q);
        reg_error:   rd_data_q <= data_w'(err_q);
        default:     rd_data_q <= '0;
      endcase
    end
  end

  assign io_rd_data  = rd_data_q;
  assign io_rd_valid = rd_valid_q;
  assign error       = |err_q;
  assign desc.addr   = addr_q;
  assign desc.len    = len_q;
  assign desc_valid  = desc_valid_q;
  assign stop        = stop_q;
  assign init        = init_q;
  assign pattern     = pattern_q;

  // a pending descriptor is only withdrawn by a stop
  assert property (@(posedge clk) disable iff (rst)
    desc_valid && !desc_ready |=> desc_valid || stop);

endmodule

/* rtl/accel_top.sv */
`timescale 1ns/1ps

module accel_top import accel_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  io_en,
  input  logic                  io_wen,
  input  logic [io_addr_w-1:0]  io_addr,
  input  logic [data_w-1:0]     io_wr_data,
  output logic [data_w-1:0]     io_rd_data,
  output logic                  io_rd_valid,
  output logic                  error,
  input  logic                  error_ack,
  output logic                  mem_rd_en,
  output logic [mem_addr_w-1:0] mem_rd_addr,
  input  logic [data_w-1:0]     mem_rd_data
);

  dma_desc_t         desc;
  logic              desc_valid;
  logic              desc_ready;
  logic              stop;
  logic              init;
  logic [data_w-1:0] pattern;
  logic              dma_busy;
  beat_t             dma_beat;
  logic              dma_valid;
  logic              dma_ready;
  beat_t             fifo_beat;
  logic              fifo_valid;
  logic              fifo_ready;
  match_t            result;
  logic              result_valid;

  accel_regs i_accel_regs (
    .clk          (clk),
    .rst          (rst),
    .io_en        (io_en),
    .io_wen       (io_wen),
    .io_addr      (io_addr),
    .io_wr_data   (io_wr_data),
    .io_rd_data   (io_rd_data),
    .io_rd_valid  (io_rd_valid),
    .error        (error),
    .error_ack    (error_ack),
    .desc         (desc),
    .desc_valid   (desc_valid),
    .desc_ready   (desc_ready),
    .stop         (stop),
    .init         (init),
    .pattern      (pattern),
    .result       (result),
    .result_valid (result_valid),
    .dma_busy     (dma_busy)
  );

  pkt_rd_dma i_pkt_rd_dma (
    .clk         (clk),
    .rst         (rst),
    .desc        (desc),
    .desc_valid  (desc_valid),
    .desc_ready  (desc_ready),
    .stop        (stop),
    .dma_busy    (dma_busy),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_addr (mem_rd_addr),
    .mem_rd_data (mem_rd_data),
    .out         (dma_beat),
    .out_valid   (dma_valid),
    .out_ready   (dma_ready)
  );

  // init flushes beats left over from a stopped job
  beat_fifo i_beat_fifo (
    .clk       (clk),
    .rst       (rst),
    .flush     (init),
    .in        (dma_beat),
    .in_valid  (dma_valid),
    .in_ready  (dma_ready),
    .out       (fifo_beat),
    .out_valid (fifo_valid),
    .out_ready (fifo_ready)
  );

  pattern_matcher i_pattern_matcher (
    .clk          (clk),
    .rst          (rst),
    .init         (init),
    .pattern      (pattern),
    .in           (fifo_beat),
    .in_valid     (fifo_valid),
    .in_ready     (fifo_ready),
    .result       (result),
    .result_valid (result_valid)
  );

endmodule

/* rtl/beat_fifo.sv */
`timescale 1ns/1ps

module beat_fifo import accel_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  logic  flush,
  input  beat_t in,
  input  logic  in_valid,
  output logic  in_ready,
  output beat_t out,
  output logic  out_valid,
  input  logic  out_ready
);

  beat_t                 mem_q [fifo_depth];
  logic [fifo_ptr_w-1:0] wr_ptr_q;
  logic [fifo_ptr_w-1:0] rd_ptr_q;
  logic [fifo_cnt_w-1:0] count_q;
  logic                  push;
  logic                  pop;

  assign in_ready  = (count_q != fifo_cnt_w'(fifo_depth));
  assign out_valid = (count_q != '0);
  assign out       = mem_q[rd_ptr_q];
  assign push      = in_valid && in_ready;
  assign pop       = out_valid && out_ready;

  always_ff @(posedge clk) begin
    if (rst || flush) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      count_q <= count_q + fifo_cnt_w'(push) - fifo_cnt_w'(pop);
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in;
    end
  end

  // occupancy stays in range and agrees with the pointer distance
  assert property (@(posedge clk) disable iff (rst)
    count_q <= fifo_cnt_w'(fifo_depth) &&
    (wr_ptr_q - rd_ptr_q) == count_q[fifo_ptr_w-1:0]);

endmodule

/* rtl/pattern_matcher.sv */
`timescale 1ns/1ps

module pattern_matcher import accel_pkg::*; (
  input  logic              clk,
  input  logic              rst,
  input  logic              init,
  input  logic [data_w-1:0] pattern,
  input  beat_t             in,
  input  logic              in_valid,
  output logic              in_ready,
  output match_t            result,
  output logic              result_valid
);

  logic [23:0]      hist_q;
  logic [len_w-1:0] pos_q;
  logic             found_q;
  logic [len_w-1:0] off_q;
  logic             done_q;
  match_t           result_q;
  logic             result_valid_q;

  logic [7:0]       win [7];
  logic             hit;
  logic [len_w-1:0] hit_off;
  logic             take;

  assign in_ready = !done_q;
  assign take     = in_valid && in_ready;

  // three history bytes, oldest first, then the four bytes of the beat
  always_comb begin
    for (int k = 0; k < 3; k++) begin
      win[k] = hist_q[8*k +: 8];
    end
    for (int k = 0; k < 4; k++) begin
      win[3+k] = in.data[8*k +: 8];
    end
  end

  // windows that end in this beat, lowest start wins
  always_comb begin
    hit     = 1'b0;
    hit_off = '0;
    for (int i = 3; i >= 0; i--) begin
      if (i < in.nbytes && pos_q >= len_w'(3 - i) &&
          {win[i+3], win[i+2], win[i+1], win[i]} == pattern) begin
        hit     = 1'b1;
        hit_off = pos_q + len_w'(i) - len_w'(3);
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst || init) begin
      pos_q          <= '0;
      found_q        <= 1'b0;
      done_q         <= 1'b0;
      result_valid_q <= 1'b0;
    end else begin
      result_valid_q <= 1'b0;
      if (take) begin
        pos_q <= pos_q + len_w'(in.nbytes);
        if (hit && !found_q) begin
          found_q <= 1'b1;
        end
        if (in.last) begin
          done_q         <= 1'b1;
          result_valid_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      // only full beats precede the last one
      hist_q <= in.data[31:8];
      if (hit && !found_q) begin
        off_q <= hit_off;
      end
      if (in.last) begin
        result_q.found  <= found_q || hit;
        result_q.offset <= found_q ? off_q : hit_off;
      end
    end
  end

  assign result       = result_q;
  assign result_valid = result_valid_q;

  // no beat may follow the last one before the next job starts
  assert property (@(posedge clk) disable iff (rst)
    done_q && !init |-> !in_valid);

endmodule

/* rtl/pkt_rd_dma.sv */
`timescale 1ns/1ps

module pkt_rd_dma import accel_pkg::*; (
  input  logic                  clk,
  input  logic                  rst,
  input  dma_desc_t             desc,
  input  logic                  desc_valid,
  output logic                  desc_ready,
  input  logic                  stop,
  output logic                  dma_busy,
  output logic                  mem_rd_en,
  output logic [mem_addr_w-1:0] mem_rd_addr,
  input  logic [data_w-1:0]     mem_rd_data,
  output beat_t                 out,
  output logic                  out_valid,
  input  logic                  out_ready
);

  logic [len_w-1:0]      rem_q;
  logic [mem_addr_w-1:0] addr_q;
  logic                  inflight_q;
  logic [2:0]            pend_nbytes_q;
  logic                  pend_last_q;
  beat_t                 skid_q [2];
  logic                  wr_ptr_q;
  logic                  rd_ptr_q;
  logic [1:0]            cnt_q;

  logic                  accept;
  logic                  pop;
  logic                  room;
  logic                  issue;
  logic [2:0]            occ;
  logic [len_w-1:0]      src_len;
  logic [mem_addr_w-1:0] src_addr;
  logic [2:0]            nb;
  logic                  is_last;

  assign dma_busy   = (rem_q != '0) || inflight_q || (cnt_q != '0);
  assign desc_ready = !dma_busy;
  assign accept     = desc_valid && desc_ready;
  assign pop        = out_valid && out_ready;

  // first read goes out in the cycle the descriptor is taken
  assign src_len  = accept ? desc.len : rem_q;
  assign src_addr = accept ? desc.addr : addr_q;
  assign nb       = (src_len >= len_w'(4)) ? 3'd4 : src_len[2:0];
  assign is_last  = (src_len <= len_w'(4));

  // skid entries plus the read in flight must fit in two slots
  assign occ   = {1'b0, cnt_q} + {2'b00, inflight_q};
  assign room  = (occ - {2'b00, pop}) < 3'd2;
  assign issue = !stop && (accept || ((rem_q != '0) && room));

  assign mem_rd_en   = issue;
  assign mem_rd_addr = src_addr;

  always_ff @(posedge clk) begin
    if (rst || stop) begin
      rem_q      <= '0;
      inflight_q <= 1'b0;
      wr_ptr_q   <= 1'b0;
      rd_ptr_q   <= 1'b0;
      cnt_q      <= '0;
    end else begin
      inflight_q <= issue;
      if (issue) begin
        rem_q <= src_len - len_w'(nb);
      end
      if (inflight_q) begin
        wr_ptr_q <= !wr_ptr_q;
      end
      if (pop) begin
        rd_ptr_q <= !rd_ptr_q;
      end
      cnt_q <= cnt_q + {1'b0, inflight_q} - {1'b0, pop};
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      addr_q        <= src_addr + 1'b1;
      pend_nbytes_q <= nb;
      pend_last_q   <= is_last;
    end
    // memory answers one cycle after the request
    if (inflight_q) begin
      skid_q[wr_ptr_q] <= '{data: mem_rd_data, nbytes: pend_nbytes_q, last: pend_last_q};
    end
  end

  assign out       = skid_q[rd_ptr_q];
  assign out_valid = (cnt_q != '0);

  assert property (@(posedge clk) disable iff (rst) occ <= 3'd2);

  assert property (@(posedge clk) disable iff (rst)
    out_valid && !out_ready && !stop |=> out_valid);

endmodule

/* run.sh */
#!/bin/sh
# build and run the pattern-search accelerator testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module accel_tb \
  -f files.f \
  -o accel_sim

./obj_dir/accel_sim | tee sim.log

if grep -qx "TEST PASSED" sim.log; then
  echo "simulation passed"
  exit 0
fi

echo "simulation failed, see sim.log"
exit 1

/* verification/accel_patterns.hex */
// memory image: 64 words, one per line, from word address 0
// then job records, all hex: addr len pattern found offset mode (0 normal, 1 stop, 2 start twice)
d4c3b2a1
00000000
c3b2a100
000000d4
b2a10000
0000d4c3
a1000000
00d4c3b2
00000000
b2a10000
0000d4c3
00000000
a1000000
a1d4c3b2
00d4c3b2
c3b2a100
000000d4
01234567
89abcdef
0f1e2d3c
77770000
00777777
16161616
17171717
18181818
19191919
1a1a1a1a
1b1b1b1b
1c1c1c1c
1d1d1d1d
1e1e1e1e
1f1f1f1f
20202020
21212121
22222222
23232323
24242424
25252525
26262626
27272727
28282828
29292929
2a2a2a2a
2b2b2b2b
2c2c2c2c
2d2d2d2d
2e2e2e2e
2f2f2f2f
30303030
31313131
32323232
33333333
34343434
35353535
36363636
37373737
38383838
39393939
3a3a3a3a
3b3b3b3b
3c3c3c3c
3d3d3d3d
3e3e3e3e
3f3f3f3f
// job records
00 8 d4c3b2a1 1 0 0
02 8 d4c3b2a1 1 1 0
04 8 d4c3b2a1 1 2 0
06 8 d4c3b2a1 1 3 0
08 c d4c3b2a1 1 6 0
0b 10 d4c3b2a1 1 7 0
0f 4 d4c3b2a1 0 0 0
0f 5 d4c3b2a1 1 1 0
11 a d4c3b2a1 0 0 0
14 8 77777777 1 2 0
00 80 d4c3b2a1 0 0 1
02 8 d4c3b2a1 1 1 0
08 c d4c3b2a1 1 6 2
00 0 d4c3b2a1 0 0 0
00 100 77777777 1 52 0
3c 10 3f3f3f3f 1 c 0

/* verification/accel_tb.sv */
`timescale 1ns/1ps

module accel_tb import accel_pkg::*; ();

  logic                  clk;
  logic                  rst;
  logic                  io_en;
  logic                  io_wen;
  logic [io_addr_w-1:0]  io_addr;
  logic [data_w-1:0]     io_wr_data;
  logic [data_w-1:0]     io_rd_data;
  logic                  io_rd_valid;
  logic                  error;
  logic                  error_ack;
  logic                  mem_rd_en;
  logic [mem_addr_w-1:0] mem_rd_addr;
  logic [data_w-1:0]     mem_rd_data = '0;

  // 64 image words, then six words per job record
  logic [31:0] vectors [256];
  logic [31:0] mem [1024];

  int num_jobs;
  int checks;
  int errors;
  int tests;
  int cycle_limit;
  int cycle_count;
  bit limit_set = 1'b0;

  // word range the current job may read, empty before the first job
  int   job_first_word = 0;
  int   job_last_word  = -1;
  logic read_in_job;

  accel_top i_accel_top (
    .clk         (clk),
    .rst         (rst),
    .io_en       (io_en),
    .io_wen      (io_wen),
    .io_addr     (io_addr),
    .io_wr_data  (io_wr_data),
    .io_rd_data  (io_rd_data),
    .io_rd_valid (io_rd_valid),
    .error       (error),
    .error_ack   (error_ack),
    .mem_rd_en   (mem_rd_en),
    .mem_rd_addr (mem_rd_addr),
    .mem_rd_data (mem_rd_data)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  assign read_in_job = (int'(mem_rd_addr) >= job_first_word) &&
                       (int'(mem_rd_addr) <= job_last_word);

  // packet memory, data one cycle after the request
  always @(posedge clk) begin
    if (mem_rd_en && !rst) begin
      checks++;
      assert (read_in_job) else begin
        $display("memory read of word %0h at %0t ns lies outside the current job",
                 mem_rd_addr, $time);
        errors++;
      end
    end
    if (mem_rd_en) begin
      mem_rd_data <= mem[mem_rd_addr];
    end
  end

  initial begin
    wait (limit_set);
    cycle_count = 0;
    while (cycle_count < cycle_limit) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("run did not finish the job list within %0d cycles", cycle_limit);
    $display("TEST FAILED");
    $finish;
  end

  task automatic expect_word(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      $display("ERROR at %0t ns: %s = %h, expected %h", $time, name, got, exp);
      errors++;
    end
  endtask

  task automatic write_reg(input logic [io_addr_w-1:0] addr, input logic [31:0] data);
    @(negedge clk);
    io_en      = 1'b1;
    io_wen     = 1'b1;
    io_addr    = addr;
    io_wr_data = data;
    @(negedge clk);
    io_en  = 1'b0;
    io_wen = 1'b0;
  endtask

  // late counts the cycles beyond the normal one-cycle answer
  task automatic read_reg(input logic [io_addr_w-1:0] addr, output logic [31:0] data,
                          output int late);
    @(negedge clk);
    io_en   = 1'b1;
    io_wen  = 1'b0;
    io_addr = addr;
    @(negedge clk);
    io_en = 1'b0;
    late  = 0;
    while (!io_rd_valid) begin
      @(negedge clk);
      late++;
    end
    data = io_rd_data;
  endtask

  task automatic check_register(input logic [io_addr_w-1:0] addr, input string name,
                                input logic [31:0] exp);
    logic [31:0] data;
    int          late;
    read_reg(addr, data, late);
    checks++;
    assert (late == 0) else begin
      $display("read of %s answered %0d cycles late", name, late);
      errors++;
    end
    expect_word(name, data, exp);
  endtask

  task automatic acknowledge_errors();
    @(negedge clk);
    error_ack = 1'b1;
    @(negedge clk);
    error_ack = 1'b0;
  endtask

  task automatic run_job(input int j);
    logic [31:0] rec_addr;
    logic [31:0] rec_len;
    logic [31:0] pattern;
    logic [31:0] exp_found;
    logic [31:0] exp_off;
    logic [31:0] mode;
    logic [31:0] data;
    logic [31:0] exp_ctrl;
    int          late;
    int          base;
    int          errors_before;
    base          = 64 + 6 * j;
    errors_before = errors;
    rec_addr      = vectors[base];
    rec_len       = vectors[base + 1];
    pattern       = vectors[base + 2];
    exp_found     = vectors[base + 3];
    exp_off       = vectors[base + 4];
    mode          = vectors[base + 5];

    // one word per started group of four bytes
    job_first_word = int'(rec_addr);
    job_last_word  = int'(rec_addr) + (int'(rec_len) + 3) / 4 - 1;

    write_reg(reg_len, rec_len);
    write_reg(reg_addr, rec_addr);
    write_reg(reg_pattern, pattern);
    write_reg(reg_ctrl, 32'h1 << ctrl_start_bit);

    if (rec_len == 0) begin
      // refused start, nothing runs
      expect_word("error", 32'(error), 32'h1);
      check_register(reg_error, "reg_error", 32'h1 << err_zero_bit);
      read_reg(reg_ctrl, data, late);
      expect_word("reg_ctrl busy", 32'(data[ctrl_busy_bit]), 32'h0);
      acknowledge_errors();
      expect_word("error", 32'(error), 32'h0);
    end else begin
      if (mode == 2) begin
        write_reg(reg_ctrl, 32'h1 << ctrl_start_bit);
        expect_word("error", 32'(error), 32'h1);
        check_register(reg_error, "reg_error", 32'h1 << err_busy_bit);
      end else if (mode == 1) begin
        repeat (2) @(negedge clk);
        write_reg(reg_ctrl, 32'h1 << ctrl_stop_bit);
      end

      // may stall until the matcher reports
      read_reg(reg_result, data, late);
      expect_word("reg_result found", 32'(data[31]), exp_found);
      if (exp_found[0]) begin
        expect_word("reg_result offset", 32'(data[len_w-1:0]), exp_off);
      end

      exp_ctrl = (32'h1 << ctrl_done_bit) | (exp_found << ctrl_match_bit);
      check_register(reg_ctrl, "reg_ctrl", exp_ctrl);

      if (mode == 2) begin
        acknowledge_errors();
        expect_word("error", 32'(error), 32'h0);
        check_register(reg_error, "reg_error", 32'h0);
      end
    end

    tests++;
    $display("job %0d addr %0h len %0d mode %0d: %s", j, rec_addr, rec_len, mode,
             (errors == errors_before) ? "ok" : "mismatch");
  endtask

  initial begin
    int total_len;
    int errors_before;
    rst        = 1'b1;
    io_en      = 1'b0;
    io_wen     = 1'b0;
    io_addr    = '0;
    io_wr_data = '0;
    error_ack  = 1'b0;
    checks     = 0;
    errors     = 0;
    tests      = 0;

    // words outside the image carry their own address
    for (int a = 0; a < 1024; a++) begin
      mem[a] = {6'h2b, ~a[9:0], 6'h15, a[9:0]};
    end
    for (int a = 0; a < 256; a++) begin
      vectors[a] = 32'hffff_ffff;
    end
    $readmemh("verification/accel_patterns.hex", vectors);
    for (int a = 0; a < 64; a++) begin
      mem[a] = vectors[a];
    end

    num_jobs  = 0;
    total_len = 0;
    while (num_jobs < 32 && vectors[64 + 6 * num_jobs] != 32'hffff_ffff) begin
      total_len += vectors[64 + 6 * num_jobs + 1];
      num_jobs++;
    end
    cycle_limit = total_len * 4 + 2000;
    limit_set   = 1'b1;

    checks++;
    assert (num_jobs > 0) else begin
      $display("no job records found in the pattern file");
      errors++;
    end

    repeat (10) @(negedge clk);
    rst = 1'b0;

    errors_before = errors;
    expect_word("error", 32'(error), 32'h0);
    check_register(reg_ctrl, "reg_ctrl", 32'h0);
    check_register(reg_error, "reg_error", 32'h0);
    tests++;
    $display("reset values: %s", (errors == errors_before) ? "ok" : "mismatch");

    for (int j = 0; j < num_jobs; j++) begin
      run_job(j);
    end

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule
